/* build.f */
+incdir+src
src/rxTxPkg.sv
src/rxTxIfs.sv
src/lcbRegs.sv
src/packetChannel.sv
src/c2sArbiter.sv
src/rxTxCore.sv
bench/rxTxBench.sv

/* Makefile */
RTL = src/rxTxPkg.sv src/rxTxIfs.sv src/lcbRegs.sv src/packetChannel.sv \
      src/c2sArbiter.sv src/rxTxCore.sv

.PHONY: all run lint clean

all: run

obj_dir/VrxTxBench: build.f $(RTL) src/rxTx_defs.svh bench/rxTxBench.sv
	verilator --binary --timing -Wno-fatal --top-module rxTxBench -f build.f

run: obj_dir/VrxTxBench
	obj_dir/VrxTxBench > sim.log 2>&1; cat sim.log
	grep -q "RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall +incdir+src --top-module rxTxCore $(RTL)

clean:
	rm -rf obj_dir sim.log

/* bench/rxTxBench.sv */
// testbench for the rxTx core with LCB stimulus, packet reference model and C2S checker
`timescale 1ns/1ns
`include "rxTx_defs.svh"

module rxTxBench
   import rxTxPkg::*;
();

   logic                  lcbClk;
   logic                  reset;
   logic [`RX_ADDR_W-1:0] lcbAddress;
   logic [`RX_DATA_W-1:0] lcbDataIn;
   logic                  lcbWrite;
   logic                  lcbRead;
   logic                  lcbCoreSelect;
   logic [`RX_DATA_W-1:0] lcbDataOut;
   logic                  lcbAck;
   logic                  trigIn;
   logic                  c2sFifoFull;
   logic [`RX_WORD_W-1:0] c2sData;
   logic                  c2sWrite;

   int errCount;
   int errAtStart;
   int testsRun;
   int testsFailed;
   int rngSeed = 32'hf09c;

   // model state per channel
   logic                  modelEnable [`RX_NUM_CHAN];
   logic [3:0]            modelLen    [`RX_NUM_CHAN];
   logic [`RX_DATA_W-1:0] modelSeed   [`RX_NUM_CHAN];
   int                    modelSeq    [`RX_NUM_CHAN];
   int                    modelCount  [`RX_NUM_CHAN];
   pktWord_u              expQ        [`RX_NUM_CHAN][$];

   int   curChan;     // channel owning the packet in flight or -1 between packets
   int   remaining;   // payload words still due
   logic fullLast;

   rxTxCore UUT (
      .lcbClk        (lcbClk),
      .reset         (reset),
      .lcbAddress    (lcbAddress),
      .lcbDataIn     (lcbDataIn),
      .lcbWrite      (lcbWrite),
      .lcbRead       (lcbRead),
      .lcbCoreSelect (lcbCoreSelect),
      .lcbDataOut    (lcbDataOut),
      .lcbAck        (lcbAck),
      .trigIn        (trigIn),
      .c2sFifoFull   (c2sFifoFull),
      .c2sData       (c2sData),
      .c2sWrite      (c2sWrite)
   );

   always #50 lcbClk = ~lcbClk;

   // expected C2S word where index 0 is the header
   function automatic pktWord_u expectWord(input int ch, input int seq, input logic [3:0] len,
                                           input logic [31:0] seedVal, input int idx);
      pktWord_u w;
      w = '0;
      if (idx == 0)
      begin
         w.header.marker  = `RX_MARKER;
         w.header.channel = 8'(ch);
         w.header.seqNum  = 16'(seq);
         w.header.length  = {4'd0, len};
         w.header.seed    = seedVal;
      end
      else
         for (int s = 0; s < 4; s++)
            w.sample[s] = seedVal + 32'(4 * (idx - 1) + s);
      return w;
   endfunction

   function automatic logic [15:0] chanAddr(input int ch, input logic [3:0] off);
      return {`RX_CHAN_SPACE, 2'b00, 2'(ch), 4'h0, off};
   endfunction

   function automatic logic allDrained();
      logic empty;
      empty = (curChan < 0);
      for (int c = 0; c < `RX_NUM_CHAN; c++)
         if (expQ[c].size() != 0)
            empty = 1'b0;
      return empty;
   endfunction

   task automatic idleCycles(input int n);
      repeat (n)
      begin
         @(posedge lcbClk);
         #10;
      end
   endtask

   // one-cycle strobe with the ack due in the very next cycle
   task automatic lcbAccess(input logic [15:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
      int cycles;
      lcbAddress    = addr;
      lcbDataIn     = wdata;
      lcbWrite      = wr;
      lcbRead       = ~wr;
      lcbCoreSelect = 1'b1;
      @(posedge lcbClk);
      #10;
      lcbCoreSelect = 1'b0;
      lcbWrite      = 1'b0;
      lcbRead       = 1'b0;
      cycles        = 0;
      while (!lcbAck && cycles < 20)
      begin
         @(posedge lcbClk);
         #10;
         cycles++;
      end
      if (!lcbAck)
      begin
         $display("timeout: no lcbAck for access at address %h", addr);
         $display("RESULT: FAIL");
         $finish;
      end
      else
      begin
         if (cycles != 0)
         begin
            $display("error: lcbAck at address %h came %0d cycles late", addr, cycles);
            errCount++;
         end
         rdata = lcbDataOut;
         @(posedge lcbClk);
         #10;
         if (lcbAck)
         begin
            $display("error: lcbAck at address %h lasted more than one cycle", addr);
            errCount++;
         end
         if (lcbDataOut != '0)
         begin
            $display("mismatch lcbDataOut after ack: got %h expected %h", lcbDataOut, 32'h0);
            errCount++;
         end
      end
   endtask

   task automatic writeReg(input logic [15:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      lcbAccess(addr, 1'b1, data, unused);
   endtask

   task automatic readCheck(input logic [15:0] addr, input logic [31:0] expected);
      logic [31:0] got;
      lcbAccess(addr, 1'b0, '0, got);
      if (got != expected)
      begin
         $display("mismatch lcbDataOut @%h: got %h expected %h", addr, got, expected);
         errCount++;
      end
   endtask

   task automatic setupChannel(input int ch, input logic en, input logic [3:0] len,
                               input logic [31:0] seedVal);
      writeReg(chanAddr(ch, `RX_CH_LEN), {28'd0, len});
      writeReg(chanAddr(ch, `RX_CH_SEED), seedVal);
      writeReg(chanAddr(ch, `RX_CH_CTRL), {31'd0, en});
      modelEnable[ch] = en;
      modelLen[ch]    = len;
      modelSeed[ch]   = seedVal;
   endtask

   task automatic queuePacket(input int ch);
      for (int k = 0; k <= modelLen[ch]; k++)
         expQ[ch].push_back(expectWord(ch, modelSeq[ch], modelLen[ch], modelSeed[ch], k));
      modelSeq[ch]++;
      modelCount[ch]++;
   endtask

   // only called with all channels idle so just the first pulse cycle starts packets
   task automatic pulseTrigger(input int width);
      trigIn = 1'b1;
      for (int c = 0; c < `RX_NUM_CHAN; c++)
         if (modelEnable[c])
            queuePacket(c);
      idleCycles(width);
      trigIn = 1'b0;
   endtask

   task automatic drainWait(input logic pressure);
      int cycles;
      cycles = 0;
      while (!allDrained() && cycles < 4000)
      begin
         if (pressure)
            c2sFifoFull = 1'($random(rngSeed) & 1);
         @(posedge lcbClk);
         #10;
         cycles++;
      end
      c2sFifoFull = 1'b0;
      if (!allDrained())
      begin
         $display("timeout: expected C2S packets did not all arrive");
         $display("RESULT: FAIL");
         $finish;
      end
   endtask

   task automatic checkC2sWord(input pktWord_u got);
      pktWord_u exp;
      int       ch;
      if (curChan < 0)
      begin
         ch = int'(got.header.channel);
         if (ch >= `RX_NUM_CHAN || expQ[ch].size() == 0)
         begin
            $display("error: C2S word %h arrived while no packet was expected", got);
            errCount++;
            return;
         end
         curChan   = ch;
         exp       = expQ[ch].pop_front();
         remaining = int'(exp.header.length);
      end
      else
      begin
         exp = expQ[curChan].pop_front();
         remaining--;
      end
      if (got != exp)
      begin
         $display("mismatch c2sData ch %0d: got %h expected %h", curChan, got, exp);
         errCount++;
      end
      if (remaining == 0)
         curChan = -1;
   endtask

   // C2S monitor on the falling edge
   always @(negedge lcbClk)
   begin
      if (reset)
      begin
         curChan  = -1;
         fullLast = 1'b0;
      end
      else
      begin
         if (c2sWrite && fullLast)
         begin
            $display("error: c2sWrite high in the cycle after c2sFifoFull was high");
            errCount++;
         end
         if (c2sWrite)
            checkC2sWord(c2sData);
         fullLast = c2sFifoFull;
      end
   end

   task automatic finishTest(input int num, input string name);
      testsRun++;
      if (errCount == errAtStart)
         $display("test %0d %s: ok", num, name);
      else
      begin
         $display("test %0d %s: failed with %0d errors", num, name, errCount - errAtStart);
         testsFailed++;
      end
      errAtStart = errCount;
   endtask

   initial
   begin
      logic [31:0] val;
      logic [3:0]  len;
      int          ch;
      lcbClk        = 1'b0;
      reset         = 1'b1;
      lcbAddress    = '0;
      lcbDataIn     = '0;
      lcbWrite      = 1'b0;
      lcbRead       = 1'b0;
      lcbCoreSelect = 1'b0;
      trigIn        = 1'b0;
      c2sFifoFull   = 1'b0;
      errCount      = 0;
      errAtStart    = 0;
      testsRun      = 0;
      testsFailed   = 0;
      curChan       = -1;
      remaining     = 0;
      for (int c = 0; c < `RX_NUM_CHAN; c++)
      begin
         modelEnable[c] = 1'b0;
         modelLen[c]    = 4'd1;
         modelSeed[c]   = '0;
         modelSeq[c]    = 0;
         modelCount[c]  = 0;
      end
      repeat (4) @(posedge lcbClk);
      #10;
      reset = 1'b0;
      idleCycles(2);

      readCheck(`RX_REG_ID, `RX_ID_VALUE);
      for (int i = 0; i < 3; i++)
      begin
         val = $random(rngSeed);
         writeReg(`RX_REG_SCRATCH, val);
         readCheck(`RX_REG_SCRATCH, val);
      end
      writeReg(16'h0040, 32'hdeadbeef);   // unmapped write is dropped
      readCheck(16'h0040, '0);
      readCheck(16'h2000, '0);
      readCheck(`RX_REG_SCRATCH, val);
      finishTest(1, "global registers");

      for (int c = 0; c < `RX_NUM_CHAN; c++)
      begin
         readCheck(chanAddr(c, `RX_CH_CTRL), '0);
         readCheck(chanAddr(c, `RX_CH_LEN), 32'd1);
         readCheck(chanAddr(c, `RX_CH_SEED), '0);
         readCheck(chanAddr(c, `RX_CH_COUNT), '0);
         val = $random(rngSeed);
         len = 4'($random(rngSeed));
         writeReg(chanAddr(c, `RX_CH_SEED), val);
         readCheck(chanAddr(c, `RX_CH_SEED), val);
         writeReg(chanAddr(c, `RX_CH_LEN), {28'd0, len});
         readCheck(chanAddr(c, `RX_CH_LEN), {28'd0, len});
         writeReg(chanAddr(c, `RX_CH_CTRL), 32'd1);
         readCheck(chanAddr(c, `RX_CH_CTRL), 32'd1);
         writeReg(chanAddr(c, `RX_CH_CTRL), 32'd0);
         readCheck(chanAddr(c, `RX_CH_CTRL), 32'd0);
      end
      finishTest(2, "channel registers");

      ch  = $random(rngSeed) & 3;
      len = 4'($random(rngSeed));
      val = $random(rngSeed);
      setupChannel(ch, 1'b1, len, val);
      pulseTrigger(1);
      drainWait(1'b0);
      idleCycles(8);
      setupChannel(ch, 1'b0, len, val);
      pulseTrigger(1);   // all disabled so no words expected
      idleCycles(40);
      finishTest(3, "single channel packet");

      for (int c = 0; c < `RX_NUM_CHAN; c++)
         setupChannel(c, 1'b1, 4'(4 * c + ($random(rngSeed) & 3)), $random(rngSeed));
      for (int t = 0; t < 3; t++)
      begin
         pulseTrigger((t == 1) ? 2 : 1);   // second cycle of a wide pulse hits busy channels
         drainWait(1'b0);
      end
      idleCycles(8);
      finishTest(4, "all channels");

      for (int t = 0; t < 4; t++)
      begin
         for (int c = 0; c < `RX_NUM_CHAN; c++)
            setupChannel(c, 1'b1, 4'($random(rngSeed)), $random(rngSeed));
         pulseTrigger(1);
         drainWait(1'b1);
      end
      idleCycles(8);
      finishTest(5, "back-pressure");

      for (int c = 0; c < `RX_NUM_CHAN; c++)
         readCheck(chanAddr(c, `RX_CH_COUNT), 32'(modelCount[c]));
      finishTest(6, "packet counts");

      $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errCount);
      if (errCount == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* src/rxTxCore.sv */
// rxTx top level with LCB decoder, four packet channels and the C2S arbiter
`timescale 1ns/1ns
`include "rxTx_defs.svh"

module rxTxCore (
   input  logic                  lcbClk,
   input  logic                  reset,
   input  logic [`RX_ADDR_W-1:0] lcbAddress,
   input  logic [`RX_DATA_W-1:0] lcbDataIn,
   input  logic                  lcbWrite,
   input  logic                  lcbRead,
   input  logic                  lcbCoreSelect,
   output logic [`RX_DATA_W-1:0] lcbDataOut,
   output logic                  lcbAck,
   input  logic                  trigIn,
   input  logic                  c2sFifoFull,
   output logic [`RX_WORD_W-1:0] c2sData,
   output logic                  c2sWrite
);

   lcbPort chanBus [`RX_NUM_CHAN] ();
   c2sPort chanC2s [`RX_NUM_CHAN] ();

   lcbRegs regs (
      .lcbClk        (lcbClk),
      .reset         (reset),
      .lcbAddress    (lcbAddress),
      .lcbDataIn     (lcbDataIn),
      .lcbWrite      (lcbWrite),
      .lcbRead       (lcbRead),
      .lcbCoreSelect (lcbCoreSelect),
      .lcbDataOut    (lcbDataOut),
      .lcbAck        (lcbAck),
      .chan          (chanBus)
   );

   for (genvar i = 0; i < `RX_NUM_CHAN; i++)
   begin : genChan
      packetChannel #(.CHANNEL(i)) channel (
         .lcbClk (lcbClk),
         .reset  (reset),
         .trigIn (trigIn),
         .bus    (chanBus[i]),
         .c2s    (chanC2s[i])
      );
   end

   c2sArbiter arbiter (
      .lcbClk      (lcbClk),
      .reset       (reset),
      .c2sFifoFull (c2sFifoFull),
      .src         (chanC2s),
      .c2sData     (c2sData),
      .c2sWrite    (c2sWrite)
   );

endmodule

/* src/c2sArbiter.sv */
// round-robin C2S arbiter, locked to one channel per packet, with registered output word
`timescale 1ns/1ns
`include "rxTx_defs.svh"

module c2sArbiter
   import rxTxPkg::*;
(
   input  logic     lcbClk,
   input  logic     reset,
   input  logic     c2sFifoFull,
   c2sPort.sink     src [`RX_NUM_CHAN],
   output pktWord_u c2sData,
   output logic     c2sWrite
);

   localparam int IDX_W = $clog2(`RX_NUM_CHAN);

   logic [`RX_NUM_CHAN-1:0] reqVec;
   logic [`RX_NUM_CHAN-1:0] lastVec;
   logic [`RX_NUM_CHAN-1:0] grantVec;
   pktWord_u                dataVec [`RX_NUM_CHAN];
   logic                    locked;
   logic [IDX_W-1:0]        owner;
   logic [IDX_W-1:0]        rrPtr;      // last packet owner
   logic [IDX_W-1:0]        pickIdx;
   logic [IDX_W-1:0]        cand;
   logic                    pickValid;
   logic [IDX_W-1:0]        curIdx;
   logic                    curValid;
   logic                    xfer;

   for (genvar i = 0; i < `RX_NUM_CHAN; i++)
   begin : genSrc
      assign reqVec[i]    = src[i].request;
      assign lastVec[i]   = src[i].last;
      assign dataVec[i]   = src[i].data;
      assign src[i].grant = grantVec[i];
   end

   // nearest requester after rrPtr wins, rrPtr itself last
   always_comb
   begin
      pickIdx   = rrPtr;
      pickValid = 1'b0;
      cand      = rrPtr;
      for (int k = `RX_NUM_CHAN; k > 0; k--)
      begin
         cand = rrPtr + IDX_W'(k);
         if (reqVec[cand])
         begin
            pickIdx   = cand;
            pickValid = 1'b1;
         end
      end
   end

   assign curIdx   = locked ? owner : pickIdx;
   assign curValid = locked | pickValid;
   assign grantVec = (curValid & ~c2sFifoFull) ?
                     ({{(`RX_NUM_CHAN-1){1'b0}}, 1'b1} << curIdx) : '0;
   assign xfer     = |(grantVec & reqVec);

   always_ff @(posedge lcbClk or posedge reset)
   begin
      if (reset)
      begin
         locked   <= 1'b0;
         owner    <= '0;
         rrPtr    <= '0;
         c2sWrite <= 1'b0;
      end
      else
      begin
         c2sWrite <= xfer;
         if (xfer)
         begin
            if (lastVec[curIdx])
            begin
               locked <= 1'b0;   // packet done, reopen arbitration
               rrPtr  <= curIdx;
            end
            else
            begin
               locked <= 1'b1;
               owner  <= curIdx;
            end
         end
      end
   end

   always_ff @(posedge lcbClk)
   begin
      if (xfer)
         c2sData <= dataVec[curIdx];
   end

endmodule

/* src/packetChannel.sv */
// triggered packet generator channel with CTRL, LEN, SEED and COUNT registers
`timescale 1ns/1ns
`include "rxTx_defs.svh"

module packetChannel
   import rxTxPkg::*;
#(
   parameter int CHANNEL = 0
) (
   input  logic   lcbClk,
   input  logic   reset,
   input  logic   trigIn,
   lcbPort.device bus,
   c2sPort.source c2s
);

   logic                  enable;
   logic [3:0]            lenReg;
   logic [`RX_DATA_W-1:0] seedReg;
   logic [`RX_DATA_W-1:0] pktCount;
   logic                  busy;
   logic                  headerPhase;
   logic [3:0]            wordIdx;      // payload words already sent
   logic [3:0]            capLen;
   logic [`RX_DATA_W-1:0] capSeed;
   logic [15:0]           seqCount;
   logic                  start;
   logic                  xfer;
   logic                  lastWord;
   logic [`RX_DATA_W-1:0] sampleBase;
   pktHeader_t            header;
   pktWord_u              word;

   // register port, ack one cycle after select
   always_ff @(posedge lcbClk or posedge reset)
   begin
      if (reset)
      begin
         enable       <= 1'b0;
         lenReg       <= 4'd1;
         seedReg      <= '0;
         bus.ack      <= 1'b0;
         bus.readData <= '0;
      end
      else
      begin
         bus.ack      <= bus.select;
         bus.readData <= '0;
         if (bus.select && bus.write)
         begin
            case (bus.offset)
               `RX_CH_CTRL: enable  <= bus.writeData[0];
               `RX_CH_LEN:  lenReg  <= bus.writeData[3:0];
               `RX_CH_SEED: seedReg <= bus.writeData;
               default:     ;
            endcase
         end
         if (bus.select && bus.read)
         begin
            case (bus.offset)
               `RX_CH_CTRL:  bus.readData <= {31'd0, enable};
               `RX_CH_LEN:   bus.readData <= {28'd0, lenReg};
               `RX_CH_SEED:  bus.readData <= seedReg;
               `RX_CH_COUNT: bus.readData <= pktCount;
               default:      bus.readData <= '0;
            endcase
         end
      end
   end

   assign start    = trigIn & enable & ~busy;   // busy or disabled drops the trigger
   assign xfer     = c2s.request & c2s.grant;
   assign lastWord = headerPhase ? (capLen == 4'd0) : (wordIdx == capLen - 4'd1);

   always_ff @(posedge lcbClk or posedge reset)
   begin
      if (reset)
      begin
         busy        <= 1'b0;
         headerPhase <= 1'b0;
         wordIdx     <= '0;
         seqCount    <= '0;
         pktCount    <= '0;
      end
      else if (start)
      begin
         busy        <= 1'b1;
         headerPhase <= 1'b1;
         wordIdx     <= '0;
      end
      else if (xfer)
      begin
         headerPhase <= 1'b0;
         if (lastWord)
         begin
            busy     <= 1'b0;
            seqCount <= seqCount + 16'd1;
            pktCount <= pktCount + 1'b1;
         end
         else if (!headerPhase)
            wordIdx <= wordIdx + 4'd1;
      end
   end

   // settings frozen for the whole packet
   always_ff @(posedge lcbClk)
   begin
      if (start)
      begin
         capLen  <= lenReg;
         capSeed <= seedReg;
      end
   end

   assign sampleBase = capSeed + {26'd0, wordIdx, 2'b00};

   always_comb
   begin
      header          = '0;
      header.marker   = `RX_MARKER;
      header.channel  = 8'(CHANNEL);
      header.seqNum   = seqCount;
      header.length   = {4'd0, capLen};
      header.seed     = capSeed;
      word            = '0;
      if (headerPhase)
         word.header = header;
      else
         for (int s = 0; s < 4; s++)
            word.sample[s] = sampleBase + s;
   end

   assign c2s.request = busy;
   assign c2s.last    = lastWord;
   assign c2s.data    = word;

endmodule

/* src/lcbRegs.sv */
// LCB address decoder with ID and scratch registers, channel steering and ack/data merge
`timescale 1ns/1ns
`include "rxTx_defs.svh"

module lcbRegs (
   input  logic                  lcbClk,
   input  logic                  reset,
   input  logic [`RX_ADDR_W-1:0] lcbAddress,
   input  logic [`RX_DATA_W-1:0] lcbDataIn,
   input  logic                  lcbWrite,
   input  logic                  lcbRead,
   input  logic                  lcbCoreSelect,
   output logic [`RX_DATA_W-1:0] lcbDataOut,
   output logic                  lcbAck,
   lcbPort.host                  chan [`RX_NUM_CHAN]
);

   logic                    strobe;
   logic                    chanHit;
   logic [1:0]              chanIdx;
   logic                    localAck;
   logic [`RX_DATA_W-1:0]   localData;
   logic [`RX_DATA_W-1:0]   scratch;
   logic [`RX_NUM_CHAN-1:0] chanAck;
   logic [`RX_DATA_W-1:0]   chanData [`RX_NUM_CHAN];

   assign strobe  = lcbCoreSelect & (lcbWrite | lcbRead);
   assign chanHit = (lcbAddress[15:12] == `RX_CHAN_SPACE);
   assign chanIdx = lcbAddress[9:8];

   // everything outside channel space is answered here, unmapped reads give zero
   always_ff @(posedge lcbClk or posedge reset)
   begin
      if (reset)
      begin
         localAck  <= 1'b0;
         localData <= '0;
         scratch   <= '0;
      end
      else
      begin
         localAck  <= strobe & ~chanHit;
         localData <= '0;
         if (strobe & ~chanHit)
         begin
            if (lcbWrite && lcbAddress == `RX_REG_SCRATCH)
               scratch <= lcbDataIn;
            if (lcbRead)
            begin
               case (lcbAddress)
                  `RX_REG_ID:      localData <= `RX_ID_VALUE;
                  `RX_REG_SCRATCH: localData <= scratch;
                  default:         localData <= '0;
               endcase
            end
         end
      end
   end

   for (genvar i = 0; i < `RX_NUM_CHAN; i++)
   begin : genPort
      assign chan[i].select    = strobe & chanHit & (chanIdx == 2'(i));
      assign chan[i].write     = lcbWrite;
      assign chan[i].read      = lcbRead;
      assign chan[i].offset    = lcbAddress[3:0];
      assign chan[i].writeData = lcbDataIn;

      assign chanAck[i]  = chan[i].ack;
      assign chanData[i] = chan[i].ack ? chan[i].readData : '0;   // only the acking source
   end

   assign lcbAck = localAck | (|chanAck);

   always_comb
   begin
      lcbDataOut = localAck ? localData : '0;
      for (int i = 0; i < `RX_NUM_CHAN; i++)
         lcbDataOut = lcbDataOut | chanData[i];
   end

endmodule

/* src/rxTxIfs.sv */
// LCB channel port and C2S word stream port linking decoder, channels and arbiter
`timescale 1ns/1ns
`include "rxTx_defs.svh"

interface lcbPort;
   logic                  select;
   logic                  write;
   logic                  read;
   logic [3:0]            offset;
   logic [`RX_DATA_W-1:0] writeData;
   logic                  ack;
   logic [`RX_DATA_W-1:0] readData;

   modport host (
      output select, write, read, offset, writeData,
      input  ack, readData
   );

   modport device (
      input  select, write, read, offset, writeData,
      output ack, readData
   );
endinterface

interface c2sPort
   import rxTxPkg::*;
();
   logic     request;   // held from header through last word
   logic     last;
   pktWord_u data;
   logic     grant;

   modport source (output request, last, data, input grant);

   modport sink (input request, last, data, output grant);
endinterface

/* src/rxTxPkg.sv */
// packet word types shared by the packet generators and the C2S arbiter
`include "rxTx_defs.svh"

package rxTxPkg;

   typedef struct packed {
      logic [7:0]            marker;
      logic [7:0]            channel;
      logic [15:0]           seqNum;
      logic [7:0]            length;      // payload words after header
      logic [55:0]           reserved;
      logic [`RX_DATA_W-1:0] seed;
   } pktHeader_t;

   // first word of a packet is read as header, the rest as samples
   typedef union packed {
      pktHeader_t                 header;
      logic [3:0][`RX_DATA_W-1:0] sample;   // sample 0 in low bits
   } pktWord_u;

endpackage

/* src/rxTx_defs.svh */
// global widths, channel count, LCB register map and packet constants for the rxTx core
`ifndef RXTX_DEFS_SVH
`define RXTX_DEFS_SVH

`define RX_DATA_W      32
`define RX_ADDR_W      16
`define RX_WORD_W      128
`define RX_NUM_CHAN    4

`define RX_MARKER      8'hA5
`define RX_ID_VALUE    32'h52580001

// global registers
`define RX_REG_ID      16'h0000
`define RX_REG_SCRATCH 16'h0004

// channel space in address bits 15..12, index in 9..8, offset in 3..0
`define RX_CHAN_SPACE  4'h1
`define RX_CH_CTRL     4'h0
`define RX_CH_LEN      4'h4
`define RX_CH_SEED     4'h8
`define RX_CH_COUNT    4'hC

`endif
